//--- hw/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

	// sprite bank size, fixed by the register map (words 0..31)
	localparam int sprite_count = 32;
	localparam int sprite_index_w = 5;

	// square sprites
	localparam int sprite_size = 16;
	localparam int sprite_offset_w = 4; // log2 of sprite_size

	// raw sprite word
	localparam int sprite_word_w = 32;
	localparam int sprite_id_w = 9;
	localparam int sprite_id_lsb = 23; // id in [31:23], 0 = disabled
	localparam int sprite_pos_msb = 22; // top bit of the x field, all layouts

	// decoded world position, wide enough for the 3x3 x field
	localparam int world_coord_w = 13;

	// packed widths of the shadow bank and the per-sprite pipeline vectors
	localparam int shadow_id_w = sprite_count * sprite_id_w;
	localparam int shadow_pos_w = sprite_count * world_coord_w;
	localparam int offs_vec_w = sprite_count * sprite_offset_w;

endpackage

`default_nettype wire

//--- hw/world_pkg.sv
`default_nettype none

package world_pkg;

	// raster coordinates, 640x480
	localparam int pixel_x_w = 10;
	localparam int pixel_y_w = 9;

	localparam int world_offset_w = 13; // scroll registers
	localparam int scroll_w = 14; // pixel + offset without wrap

	localparam int reg_addr_w = 8;
	localparam int reg_data_w = 32;

	// how the sprite word splits its position bits
	typedef enum logic [1:0] {
		world_3x3 = 2'd0, // x [22:10], y [9:0]
		world_9x1 = 2'd1, // x [22:13], y [9:0]
		world_1x9 = 2'd2, // x [22:11], y [10:0]
		world_reserved = 2'd3
	} world_type_e;

	// host register map, sprite words sit below reg_offset_x
	typedef enum logic [7:0] {
		reg_sprite_last = 8'd31,
		reg_offset_x = 8'd32,
		reg_offset_y = 8'd33,
		reg_world_type = 8'd34,
		reg_commit = 8'd35
	} reg_addr_e;

endpackage

`default_nettype wire

//--- hw/sprite_regfile.sv
`default_nettype none

module sprite_regfile (
	input wire clk,
	input wire reset_n,
	input wire write,
	input wire [world_pkg::reg_addr_w-1:0] address,
	input wire [world_pkg::reg_data_w-1:0] writedata,
	input wire latch_sprites,
	output logic [sprite_pkg::shadow_id_w-1:0] shadow_id,
	output logic [sprite_pkg::shadow_pos_w-1:0] shadow_x,
	output logic [sprite_pkg::shadow_pos_w-1:0] shadow_y,
	output logic [world_pkg::world_offset_w-1:0] offset_x,
	output logic [world_pkg::world_offset_w-1:0] offset_y
);

	logic [sprite_pkg::sprite_word_w-1:0] sprite_words [0:sprite_pkg::sprite_count-1];
	world_pkg::world_type_e world_type;
	logic commit_pulse;

	function automatic logic [sprite_pkg::world_coord_w-1:0] decode_x(
		input logic [sprite_pkg::sprite_word_w-1:0] word,
		input world_pkg::world_type_e wtype
	);
		case (wtype)
			world_pkg::world_3x3: decode_x = word[sprite_pkg::sprite_pos_msb:10];
			world_pkg::world_9x1: decode_x = {3'b000, word[sprite_pkg::sprite_pos_msb:13]};
			world_pkg::world_1x9: decode_x = {1'b0, word[sprite_pkg::sprite_pos_msb:11]};
			default: decode_x = '0;
		endcase
	endfunction

	function automatic logic [sprite_pkg::world_coord_w-1:0] decode_y(
		input logic [sprite_pkg::sprite_word_w-1:0] word,
		input world_pkg::world_type_e wtype
	);
		case (wtype)
			world_pkg::world_3x3,
			world_pkg::world_9x1: decode_y = {3'b000, word[9:0]};
			world_pkg::world_1x9: decode_y = {2'b00, word[10:0]};
			default: decode_y = '0;
		endcase
	endfunction

	// host side register writes
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < sprite_pkg::sprite_count; i++) begin
				sprite_words[i] <= '0;
			end
			offset_x <= '0;
			offset_y <= '0;
			world_type <= world_pkg::world_3x3;
			commit_pulse <= 1'b0;
		end else begin
			commit_pulse <= write && (address == world_pkg::reg_commit);
			if (write) begin
				case (address)
					world_pkg::reg_offset_x: offset_x <= writedata[world_pkg::world_offset_w-1:0];
					world_pkg::reg_offset_y: offset_y <= writedata[world_pkg::world_offset_w-1:0];
					world_pkg::reg_world_type: begin
						if (writedata[1:0] != world_pkg::world_reserved) // keep old layout
							world_type <= world_pkg::world_type_e'(writedata[1:0]);
					end
					default: begin
						if (address <= world_pkg::reg_sprite_last)
							sprite_words[address[sprite_pkg::sprite_index_w-1:0]] <= writedata;
					end
				endcase
			end
		end
	end

	// shadow bank, decoded with the layout current at load time
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			shadow_id <= '0; // all sprites disabled
			shadow_x <= '0;
			shadow_y <= '0;
		end else if (commit_pulse || latch_sprites) begin
			for (int i = 0; i < sprite_pkg::sprite_count; i++) begin
				shadow_id[i*sprite_pkg::sprite_id_w +: sprite_pkg::sprite_id_w] <=
					sprite_words[i][sprite_pkg::sprite_word_w-1:sprite_pkg::sprite_id_lsb];
				shadow_x[i*sprite_pkg::world_coord_w +: sprite_pkg::world_coord_w] <=
					decode_x(sprite_words[i], world_type);
				shadow_y[i*sprite_pkg::world_coord_w +: sprite_pkg::world_coord_w] <=
					decode_y(sprite_words[i], world_type);
			end
		end
	end

	a_world_type_valid: assert property (
		@(posedge clk) disable iff (!reset_n)
		world_type != world_pkg::world_reserved
	);

endmodule

`default_nettype wire

//--- hw/sprite_hit_test.sv
`default_nettype none

module sprite_hit_test (
	input wire clk,
	input wire reset_n,
	input wire [world_pkg::pixel_x_w-1:0] pixel_x,
	input wire [world_pkg::pixel_y_w-1:0] pixel_y,
	input wire pixel_valid,
	input wire [sprite_pkg::shadow_id_w-1:0] shadow_id,
	input wire [sprite_pkg::shadow_pos_w-1:0] shadow_x,
	input wire [sprite_pkg::shadow_pos_w-1:0] shadow_y,
	input wire [world_pkg::world_offset_w-1:0] offset_x,
	input wire [world_pkg::world_offset_w-1:0] offset_y,
	output logic [sprite_pkg::sprite_count-1:0] visible_mask,
	output logic [sprite_pkg::offs_vec_w-1:0] sprite_offs_x,
	output logic [sprite_pkg::offs_vec_w-1:0] sprite_offs_y,
	output logic [sprite_pkg::shadow_id_w-1:0] ids_out,
	output logic hit_valid
);

	logic [world_pkg::scroll_w-1:0] world_x;
	logic [world_pkg::scroll_w-1:0] world_y;
	logic [sprite_pkg::sprite_count-1:0] vis_next;
	logic [sprite_pkg::offs_vec_w-1:0] offs_x_next;
	logic [sprite_pkg::offs_vec_w-1:0] offs_y_next;

	// scrolled pixel position in world space
	assign world_x = {{(world_pkg::scroll_w - world_pkg::pixel_x_w){1'b0}}, pixel_x}
		+ {{(world_pkg::scroll_w - world_pkg::world_offset_w){1'b0}}, offset_x};
	assign world_y = {{(world_pkg::scroll_w - world_pkg::pixel_y_w){1'b0}}, pixel_y}
		+ {{(world_pkg::scroll_w - world_pkg::world_offset_w){1'b0}}, offset_y};

	for (genvar i = 0; i < sprite_pkg::sprite_count; i++) begin : g_sprite
		logic [sprite_pkg::sprite_id_w-1:0] id;
		logic [world_pkg::scroll_w:0] diff_x; // extra bit catches pixel left of box
		logic [world_pkg::scroll_w:0] diff_y;

		assign id = shadow_id[i*sprite_pkg::sprite_id_w +: sprite_pkg::sprite_id_w];
		assign diff_x = {1'b0, world_x}
			- {{(world_pkg::scroll_w + 1 - sprite_pkg::world_coord_w){1'b0}},
			shadow_x[i*sprite_pkg::world_coord_w +: sprite_pkg::world_coord_w]};
		assign diff_y = {1'b0, world_y}
			- {{(world_pkg::scroll_w + 1 - sprite_pkg::world_coord_w){1'b0}},
			shadow_y[i*sprite_pkg::world_coord_w +: sprite_pkg::world_coord_w]};

		// inside the box when the difference is 0..15
		assign vis_next[i] = (id != '0)
			&& (diff_x[world_pkg::scroll_w:sprite_pkg::sprite_offset_w] == '0)
			&& (diff_y[world_pkg::scroll_w:sprite_pkg::sprite_offset_w] == '0);
		assign offs_x_next[i*sprite_pkg::sprite_offset_w +: sprite_pkg::sprite_offset_w] =
			diff_x[sprite_pkg::sprite_offset_w-1:0];
		assign offs_y_next[i*sprite_pkg::sprite_offset_w +: sprite_pkg::sprite_offset_w] =
			diff_y[sprite_pkg::sprite_offset_w-1:0];

		a_mask_needs_id: assert property (
			@(posedge clk) disable iff (!reset_n)
			visible_mask[i] |-> ids_out[i*sprite_pkg::sprite_id_w +: sprite_pkg::sprite_id_w] != '0
		);
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			visible_mask <= '0;
			sprite_offs_x <= '0;
			sprite_offs_y <= '0;
			ids_out <= '0;
			hit_valid <= 1'b0;
		end else begin
			visible_mask <= pixel_valid ? vis_next : '0;
			sprite_offs_x <= offs_x_next;
			sprite_offs_y <= offs_y_next;
			ids_out <= shadow_id; // ids travel with the mask
			hit_valid <= pixel_valid;
		end
	end

endmodule

`default_nettype wire

//--- hw/sprite_priority.sv
`default_nettype none

module sprite_priority (
	input wire clk,
	input wire reset_n,
	input wire [sprite_pkg::sprite_count-1:0] visible_mask,
	input wire [sprite_pkg::offs_vec_w-1:0] sprite_offs_x,
	input wire [sprite_pkg::offs_vec_w-1:0] sprite_offs_y,
	input wire [sprite_pkg::shadow_id_w-1:0] ids_out,
	input wire hit_valid,
	output logic out_valid,
	output logic hit,
	output logic [sprite_pkg::sprite_index_w-1:0] sprite_index,
	output logic [sprite_pkg::sprite_id_w-1:0] sprite_id,
	output logic [sprite_pkg::sprite_offset_w-1:0] sprite_offset_x,
	output logic [sprite_pkg::sprite_offset_w-1:0] sprite_offset_y,
	output logic border
);

	logic [sprite_pkg::sprite_index_w-1:0] sel;
	logic take;
	logic [sprite_pkg::sprite_id_w-1:0] sel_id;
	logic [sprite_pkg::sprite_offset_w-1:0] sel_ox;
	logic [sprite_pkg::sprite_offset_w-1:0] sel_oy;
	logic sel_border;

	// scan from the top so the lowest index is the last to win
	always_comb begin
		sel = '0;
		for (int i = sprite_pkg::sprite_count - 1; i >= 0; i--) begin
			if (visible_mask[i])
				sel = i[sprite_pkg::sprite_index_w-1:0];
		end
	end

	assign take = hit_valid && (|visible_mask);
	assign sel_id = ids_out[sel*sprite_pkg::sprite_id_w +: sprite_pkg::sprite_id_w];
	assign sel_ox = sprite_offs_x[sel*sprite_pkg::sprite_offset_w +: sprite_pkg::sprite_offset_w];
	assign sel_oy = sprite_offs_y[sel*sprite_pkg::sprite_offset_w +: sprite_pkg::sprite_offset_w];

	assign sel_border = (sel_ox == '0) || (sel_ox == sprite_pkg::sprite_size - 1)
		|| (sel_oy == '0) || (sel_oy == sprite_pkg::sprite_size - 1);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			out_valid <= 1'b0;
			hit <= 1'b0;
			sprite_index <= '0;
			sprite_id <= '0;
			sprite_offset_x <= '0;
			sprite_offset_y <= '0;
			border <= 1'b0;
		end else begin
			out_valid <= hit_valid;
			hit <= take;
			if (take) begin
				sprite_index <= sel;
				sprite_id <= sel_id;
				sprite_offset_x <= sel_ox;
				sprite_offset_y <= sel_oy;
				border <= sel_border;
			end else begin
				sprite_index <= '0; // misses report all zero
				sprite_id <= '0;
				sprite_offset_x <= '0;
				sprite_offset_y <= '0;
				border <= 1'b0;
			end
		end
	end

	a_hit_has_id: assert property (
		@(posedge clk) disable iff (!reset_n)
		hit |-> (out_valid && sprite_id != '0)
	);

endmodule

`default_nettype wire

//--- hw/sprite_engine.sv
`default_nettype none

module sprite_engine (
	input wire clk,
	input wire reset_n,
	input wire write,
	input wire [world_pkg::reg_addr_w-1:0] address,
	input wire [world_pkg::reg_data_w-1:0] writedata,
	input wire latch_sprites,
	input wire [world_pkg::pixel_x_w-1:0] pixel_x,
	input wire [world_pkg::pixel_y_w-1:0] pixel_y,
	input wire pixel_valid,
	output logic out_valid,
	output logic hit,
	output logic [sprite_pkg::sprite_index_w-1:0] sprite_index,
	output logic [sprite_pkg::sprite_id_w-1:0] sprite_id,
	output logic [sprite_pkg::sprite_offset_w-1:0] sprite_offset_x,
	output logic [sprite_pkg::sprite_offset_w-1:0] sprite_offset_y,
	output logic border
);

	// decode to execute
	wire [sprite_pkg::shadow_id_w-1:0] shadow_id;
	wire [sprite_pkg::shadow_pos_w-1:0] shadow_x;
	wire [sprite_pkg::shadow_pos_w-1:0] shadow_y;
	wire [world_pkg::world_offset_w-1:0] offset_x;
	wire [world_pkg::world_offset_w-1:0] offset_y;

	// execute to result
	wire [sprite_pkg::sprite_count-1:0] visible_mask;
	wire [sprite_pkg::offs_vec_w-1:0] sprite_offs_x;
	wire [sprite_pkg::offs_vec_w-1:0] sprite_offs_y;
	wire [sprite_pkg::shadow_id_w-1:0] ids_out;
	wire hit_valid;

	sprite_regfile u_regfile (
		.clk(clk),
		.reset_n(reset_n),
		.write(write),
		.address(address),
		.writedata(writedata),
		.latch_sprites(latch_sprites),
		.shadow_id(shadow_id),
		.shadow_x(shadow_x),
		.shadow_y(shadow_y),
		.offset_x(offset_x),
		.offset_y(offset_y)
	);

	sprite_hit_test u_hit_test (
		.clk(clk),
		.reset_n(reset_n),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.pixel_valid(pixel_valid),
		.shadow_id(shadow_id),
		.shadow_x(shadow_x),
		.shadow_y(shadow_y),
		.offset_x(offset_x),
		.offset_y(offset_y),
		.visible_mask(visible_mask),
		.sprite_offs_x(sprite_offs_x),
		.sprite_offs_y(sprite_offs_y),
		.ids_out(ids_out),
		.hit_valid(hit_valid)
	);

	sprite_priority u_priority (
		.clk(clk),
		.reset_n(reset_n),
		.visible_mask(visible_mask),
		.sprite_offs_x(sprite_offs_x),
		.sprite_offs_y(sprite_offs_y),
		.ids_out(ids_out),
		.hit_valid(hit_valid),
		.out_valid(out_valid),
		.hit(hit),
		.sprite_index(sprite_index),
		.sprite_id(sprite_id),
		.sprite_offset_x(sprite_offset_x),
		.sprite_offset_y(sprite_offset_y),
		.border(border)
	);

endmodule

`default_nettype wire

//--- tests/sprite_engine_tb.sv
`default_nettype none

module sprite_engine_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int drain_limit = 20; // cycles allowed for the last results

	typedef struct packed {
		logic hit;
		logic [sprite_pkg::sprite_index_w-1:0] index;
		logic [sprite_pkg::sprite_id_w-1:0] id;
		logic [sprite_pkg::sprite_offset_w-1:0] ox;
		logic [sprite_pkg::sprite_offset_w-1:0] oy;
		logic border;
	} expect_t;

	logic clk;
	logic reset_n;
	logic write;
	logic [world_pkg::reg_addr_w-1:0] address;
	logic [world_pkg::reg_data_w-1:0] writedata;
	logic latch_sprites;
	logic [world_pkg::pixel_x_w-1:0] pixel_x;
	logic [world_pkg::pixel_y_w-1:0] pixel_y;
	logic pixel_valid;
	logic out_valid;
	logic hit;
	logic [sprite_pkg::sprite_index_w-1:0] sprite_index;
	logic [sprite_pkg::sprite_id_w-1:0] sprite_id;
	logic [sprite_pkg::sprite_offset_w-1:0] sprite_offset_x;
	logic [sprite_pkg::sprite_offset_w-1:0] sprite_offset_y;
	logic border;

	expect_t exp_q[$]; // probes in flight, oldest first

	sprite_engine uut (.*);

	always #5 clk = ~clk;

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_field(input string name, input int got, input int want);
		assert (got == want) else
			stop_with_failure($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
				$time, name, got, want));
	endtask

	task automatic check_result(input expect_t want);
		check_field("hit", hit, want.hit);
		check_field("sprite_index", sprite_index, want.index);
		check_field("sprite_id", sprite_id, want.id);
		check_field("sprite_offset_x", sprite_offset_x, want.ox);
		check_field("sprite_offset_y", sprite_offset_y, want.oy);
		check_field("border", border, want.border);
	endtask

	// mid cycle, outputs are stable here
	always @(negedge clk) begin : compare_outputs
		expect_t want;
		want = '0; // idle cycles report all zero
		if (out_valid) begin
			assert (exp_q.size() > 0) else
				stop_with_failure("out_valid went high with no probe outstanding");
			want = exp_q.pop_front();
		end
		check_result(want);
	end

	// inputs change 1 ns after the edge, strobes last one cycle
	task automatic next_slot();
		@(posedge clk);
		#1;
		write = 1'b0;
		latch_sprites = 1'b0;
		pixel_valid = 1'b0;
	endtask

	task automatic do_write(input int addr, input logic [31:0] data);
		next_slot();
		write = 1'b1;
		address = addr[world_pkg::reg_addr_w-1:0];
		writedata = data;
	endtask

	task automatic do_probe(input int px, input int py, input expect_t want);
		next_slot();
		pixel_valid = 1'b1;
		pixel_x = px[world_pkg::pixel_x_w-1:0];
		pixel_y = py[world_pkg::pixel_y_w-1:0];
		exp_q.push_back(want);
	endtask

	initial begin : run_commands
		int fd;
		int n;
		int a;
		int px;
		int py;
		int ph;
		int pi;
		int pid;
		int pox;
		int poy;
		int pb;
		int wait_cycles;
		logic ok;
		logic [31:0] d;
		string line;
		string cmd;
		expect_t want;

		clk = 1'b0;
		reset_n = 1'b0;
		write = 1'b0;
		address = '0;
		writedata = '0;
		latch_sprites = 1'b0;
		pixel_x = '0;
		pixel_y = '0;
		pixel_valid = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset_n = 1'b1;

		fd = $fopen("tests/sprite_engine_testdata.txt", "r");
		if (fd == 0)
			stop_with_failure("cannot open tests/sprite_engine_testdata.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			n = $sscanf(line, "%s", cmd);
			if (n < 1 || cmd.getc(0) == "#")
				continue; // blank or comment
			case (cmd)
				"W": begin
					ok = ($sscanf(line, "%s %d %h", cmd, a, d) == 3);
					if (ok)
						do_write(a, d);
				end
				"L": begin
					ok = 1'b1;
					next_slot();
					latch_sprites = 1'b1;
				end
				"I": begin
					ok = ($sscanf(line, "%s %d", cmd, a) == 2);
					for (int i = 0; ok && i < a; i++)
						next_slot();
				end
				"P": begin
					ok = ($sscanf(line, "%s %d %d %d %d %d %d %d %d",
						cmd, px, py, ph, pi, pid, pox, poy, pb) == 9);
					want.hit = ph[0];
					want.index = pi[sprite_pkg::sprite_index_w-1:0];
					want.id = pid[sprite_pkg::sprite_id_w-1:0];
					want.ox = pox[sprite_pkg::sprite_offset_w-1:0];
					want.oy = poy[sprite_pkg::sprite_offset_w-1:0];
					want.border = pb[0];
					if (ok)
						do_probe(px, py, want);
				end
				default: ok = 1'b0;
			endcase
			if (!ok)
				stop_with_failure($sformatf("malformed line in data file: %s", line));
		end
		$fclose(fd);
		next_slot();

		for (wait_cycles = 0; wait_cycles < drain_limit && exp_q.size() > 0; wait_cycles++)
			@(posedge clk);
		if (exp_q.size() != 0) begin
			stop_with_failure($sformatf("timeout, %0d probes never produced out_valid",
				exp_q.size()));
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tests/sprite_engine_testdata.txt
# W addr data: addr decimal, data hex | L: latch | I n: idle cycles
# P x y hit index id ox oy border: probe and expected result, all decimal
W 0 02819032
P 100 50 0 0 0 0 0 0
W 35 0
I 2
P 100 50 1 0 5 0 0 1
P 115 65 1 0 5 15 15 1
P 99 50 0 0 0 0 0 0
P 100 66 0 0 0 0 0 0
P 108 65 1 0 5 8 15 1
W 0 0303212C
P 200 300 0 0 0 0 0 0
L
P 200 300 1 0 6 0 0 1
P 100 50 0 0 0 0 0 0
W 34 1
W 35 0
I 2
P 25 300 1 0 6 0 0 1
P 40 315 1 0 6 15 15 1
P 24 300 0 0 0 0 0 0
W 34 2
W 35 0
I 2
P 100 300 1 0 6 0 0 1
P 115 315 1 0 6 15 15 1
P 100 316 0 0 0 0 0 0
W 34 3
W 35 0
I 2
P 100 300 1 0 6 0 0 1
W 32 32
W 33 14
P 50 280 1 0 6 0 0 1
P 57 290 1 0 6 7 10 0
P 49 280 0 0 0 0 0 0
W 32 0
W 33 0
W 34 0
W 3 0D04B0C8
W 7 FF84D0CC
W 35 0
I 2
P 305 202 1 3 26 5 2 0
P 310 206 1 3 26 10 6 0
P 315 215 1 3 26 15 15 1
P 307 218 0 0 0 0 0 0
P 308 218 1 7 511 0 14 1
P 309 218 1 7 511 1 14 0
P 323 218 1 7 511 15 14 1
P 324 218 0 0 0 0 0 0

//--- sprite_engine.f
hw/sprite_pkg.sv
hw/world_pkg.sv
hw/sprite_regfile.sv
hw/sprite_hit_test.sv
hw/sprite_priority.sv
hw/sprite_engine.sv
tests/sprite_engine_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS := --binary --timing --assert -Wno-fatal -j 0
TOP := sprite_engine_tb
FILELIST := sprite_engine.f
OBJ_DIR := obj_dir

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a $fatal in the testbench gives a nonzero exit status
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
